// ==== logic/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// core sizes
`define OOO_XLEN      32
`define OOO_NUM_REGS  32
`define OOO_NUM_SLOTS 4
`define OOO_ROB_DEPTH 8

// alu op codes
// shifts use the low five bits of operand b
`define OOO_OP_ADD 3'd0
`define OOO_OP_SUB 3'd1
`define OOO_OP_AND 3'd2
`define OOO_OP_OR  3'd3
`define OOO_OP_XOR 3'd4
`define OOO_OP_SLL 3'd5
`define OOO_OP_SRL 3'd6
`define OOO_OP_SLT 3'd7

`endif

// ==== logic/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]               word_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0]  reg_addr_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [2:0]                        alu_op_t;

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAIT,
        SLOT_READY
    } slot_state_t;

    // integer alu of the issue slots
    function automatic word_t alu_compute(alu_op_t op, word_t a, word_t b);
        word_t res;
        case (op)
            `OOO_OP_ADD: res = a + b;
            `OOO_OP_SUB: res = a - b;
            `OOO_OP_AND: res = a & b;
            `OOO_OP_OR:  res = a | b;
            `OOO_OP_XOR: res = a ^ b;
            `OOO_OP_SLL: res = a << b[4:0];
            `OOO_OP_SRL: res = a >> b[4:0];
            // signed compare
            `OOO_OP_SLT: res = word_t'($signed(a) < $signed(b));
            default:     res = '0;
        endcase
        return res;
    endfunction

endpackage

// ==== logic/rename_dispatch.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module rename_dispatch (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      instr_valid_i,
    input  ooo_pkg::alu_op_t          instr_op_i,
    input  ooo_pkg::reg_addr_t        instr_rd_i,
    input  ooo_pkg::reg_addr_t        instr_rs1_i,
    input  ooo_pkg::reg_addr_t        instr_rs2_i,
    input  ooo_pkg::word_t            instr_imm_i,
    input  logic                      instr_use_imm_i,
    output logic                      instr_ready_o,

    input  logic [`OOO_NUM_SLOTS-1:0] slot_free_i,
    output logic [`OOO_NUM_SLOTS-1:0] slot_load_o,

    input  ooo_pkg::rob_tag_t         rob_tag_i,
    input  logic                      rob_full_i,
    input  logic [`OOO_ROB_DEPTH-1:0] rob_done_i,
    input  ooo_pkg::word_t            rob_data_i [`OOO_ROB_DEPTH],
    output logic                      alloc_valid_o,
    output ooo_pkg::reg_addr_t        alloc_rd_o,

    input  logic                      cdb_valid_i,
    input  ooo_pkg::rob_tag_t         cdb_tag_i,
    input  ooo_pkg::word_t            cdb_data_i,

    input  logic                      commit_fire_i,
    input  ooo_pkg::reg_addr_t        commit_rd_i,
    input  ooo_pkg::rob_tag_t         commit_tag_i,
    input  ooo_pkg::word_t            commit_data_i,

    output ooo_pkg::alu_op_t          disp_op_o,
    output ooo_pkg::rob_tag_t         disp_tag_o,
    output logic                      disp_src1_ready_o,
    output ooo_pkg::rob_tag_t         disp_src1_tag_o,
    output ooo_pkg::word_t            disp_src1_data_o,
    output logic                      disp_src2_ready_o,
    output ooo_pkg::rob_tag_t         disp_src2_tag_o,
    output ooo_pkg::word_t            disp_src2_data_o
);

    // alias table and architectural registers
    logic [`OOO_NUM_REGS-1:0] busy;
    ooo_pkg::rob_tag_t        rat_tag [`OOO_NUM_REGS];
    ooo_pkg::word_t           rf      [`OOO_NUM_REGS];

    logic                     active;
    logic                     fire;
    logic [`OOO_NUM_SLOTS-1:0] slot_pick;

    ooo_pkg::reg_addr_t       src_addr  [2];
    ooo_pkg::rob_tag_t        src_tag   [2];
    logic                     src_ready [2];
    ooo_pkg::word_t           src_data  [2];

    assign instr_ready_o = active && !rob_full_i && (|slot_free_i);
    assign fire          = instr_valid_i && instr_ready_o;

    // lowest free slot
    assign slot_pick     = slot_free_i & (~slot_free_i + 1'b1);
    assign slot_load_o   = fire ? slot_pick : '0;

    assign alloc_valid_o = fire;
    assign alloc_rd_o    = instr_rd_i;
    assign disp_op_o     = instr_op_i;
    assign disp_tag_o    = rob_tag_i;

    // operand from the regfile, a finished rob entry or this cycle's bus
    always_comb begin
        src_addr[0] = instr_rs1_i;
        src_addr[1] = instr_rs2_i;
        for (int k = 0; k < 2; k++) begin
            src_tag[k]   = rat_tag[src_addr[k]];
            src_ready[k] = 1'b1;
            src_data[k]  = '0;
            if (src_addr[k] == '0) begin
                src_data[k] = '0;
            end else if (!busy[src_addr[k]]) begin
                src_data[k] = rf[src_addr[k]];
            end else if (rob_done_i[src_tag[k]]) begin
                src_data[k] = rob_data_i[src_tag[k]];
            end else if (cdb_valid_i && cdb_tag_i == src_tag[k]) begin
                src_data[k] = cdb_data_i;
            end else begin
                src_ready[k] = 1'b0;
            end
        end
    end

    assign disp_src1_ready_o = src_ready[0];
    assign disp_src1_tag_o   = src_tag[0];
    assign disp_src1_data_o  = src_data[0];

    // immediate takes the place of rs2
    assign disp_src2_ready_o = instr_use_imm_i ? 1'b1 : src_ready[1];
    assign disp_src2_tag_o   = src_tag[1];
    assign disp_src2_data_o  = instr_use_imm_i ? instr_imm_i : src_data[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            busy   <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                rf[i] <= ooo_pkg::word_t'(i);
            end
        end else begin
            active <= 1'b1;
            if (commit_fire_i && commit_rd_i != '0) begin
                rf[commit_rd_i] <= commit_data_i;
                // only release if no younger writer took the entry
                if (rat_tag[commit_rd_i] == commit_tag_i) begin
                    busy[commit_rd_i] <= 1'b0;
                end
            end
            if (fire && instr_rd_i != '0) begin
                busy[instr_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && instr_rd_i != '0) begin
            rat_tag[instr_rd_i] <= rob_tag_i;
        end
    end

endmodule

// ==== logic/issue_slot.sv ====
`timescale 1ns/1ns

module issue_slot (
    input  logic               clk,
    input  logic               rst,

    input  logic               load_i,
    input  ooo_pkg::alu_op_t   disp_op_i,
    input  ooo_pkg::rob_tag_t  disp_tag_i,
    input  logic               disp_src1_ready_i,
    input  ooo_pkg::rob_tag_t  disp_src1_tag_i,
    input  ooo_pkg::word_t     disp_src1_data_i,
    input  logic               disp_src2_ready_i,
    input  ooo_pkg::rob_tag_t  disp_src2_tag_i,
    input  ooo_pkg::word_t     disp_src2_data_i,

    input  logic               cdb_valid_i,
    input  ooo_pkg::rob_tag_t  cdb_tag_i,
    input  ooo_pkg::word_t     cdb_data_i,

    input  logic               grant_i,
    output logic               free_o,
    output logic               req_o,
    output ooo_pkg::rob_tag_t  tag_o,
    output ooo_pkg::word_t     result_o
);

    ooo_pkg::slot_state_t state;

    ooo_pkg::alu_op_t  op;
    ooo_pkg::rob_tag_t dest_tag;
    logic              have1, have2;
    ooo_pkg::rob_tag_t tag1, tag2;
    ooo_pkg::word_t    data1, data2;
    logic              hit1, hit2;

    // wakeup on a matching broadcast
    assign hit1 = (state == ooo_pkg::SLOT_WAIT) && cdb_valid_i && !have1 && cdb_tag_i == tag1;
    assign hit2 = (state == ooo_pkg::SLOT_WAIT) && cdb_valid_i && !have2 && cdb_tag_i == tag2;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ooo_pkg::SLOT_FREE;
        end else begin
            case (state)
                ooo_pkg::SLOT_FREE: begin
                    if (load_i) begin
                        state <= (disp_src1_ready_i && disp_src2_ready_i) ?
                                 ooo_pkg::SLOT_READY : ooo_pkg::SLOT_WAIT;
                    end
                end
                ooo_pkg::SLOT_WAIT: begin
                    if ((have1 || hit1) && (have2 || hit2)) begin
                        state <= ooo_pkg::SLOT_READY;
                    end
                end
                ooo_pkg::SLOT_READY: begin
                    if (grant_i) begin
                        state <= ooo_pkg::SLOT_FREE;
                    end
                end
                default: state <= ooo_pkg::SLOT_FREE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            op       <= disp_op_i;
            dest_tag <= disp_tag_i;
            have1    <= disp_src1_ready_i;
            tag1     <= disp_src1_tag_i;
            data1    <= disp_src1_data_i;
            have2    <= disp_src2_ready_i;
            tag2     <= disp_src2_tag_i;
            data2    <= disp_src2_data_i;
        end else begin
            if (hit1) begin
                have1 <= 1'b1;
                data1 <= cdb_data_i;
            end
            if (hit2) begin
                have2 <= 1'b1;
                data2 <= cdb_data_i;
            end
        end
    end

    assign free_o   = (state == ooo_pkg::SLOT_FREE);
    assign req_o    = (state == ooo_pkg::SLOT_READY);
    assign tag_o    = dest_tag;
    assign result_o = ooo_pkg::alu_compute(op, data1, data2);

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      alloc_valid_i,
    input  ooo_pkg::reg_addr_t        alloc_rd_i,
    output ooo_pkg::rob_tag_t         alloc_tag_o,
    output logic                      full_o,
    output logic [`OOO_ROB_DEPTH-1:0] done_o,
    output ooo_pkg::word_t            data_o [`OOO_ROB_DEPTH],

    input  logic [`OOO_NUM_SLOTS-1:0] slot_req_i,
    input  ooo_pkg::rob_tag_t         slot_tag_i    [`OOO_NUM_SLOTS],
    input  ooo_pkg::word_t            slot_result_i [`OOO_NUM_SLOTS],
    output logic [`OOO_NUM_SLOTS-1:0] slot_grant_o,

    output logic                      cdb_valid_o,
    output ooo_pkg::rob_tag_t         cdb_tag_o,
    output ooo_pkg::word_t            cdb_data_o,

    input  logic                      commit_ready_i,
    output logic                      commit_valid_o,
    output ooo_pkg::reg_addr_t        commit_rd_o,
    output ooo_pkg::rob_tag_t         commit_tag_o,
    output ooo_pkg::word_t            commit_data_o
);

    localparam int CNT_W = $clog2(`OOO_ROB_DEPTH) + 1;

    ooo_pkg::rob_tag_t        head;
    ooo_pkg::rob_tag_t        tail;
    logic [CNT_W-1:0]         count;

    logic [`OOO_ROB_DEPTH-1:0] done;
    ooo_pkg::reg_addr_t       entry_rd  [`OOO_ROB_DEPTH];
    ooo_pkg::word_t           entry_val [`OOO_ROB_DEPTH];

    logic                     commit_fire;

    assign alloc_tag_o = tail;
    assign full_o      = (count == CNT_W'(`OOO_ROB_DEPTH));
    assign done_o      = done;
    assign data_o      = entry_val;

    // lowest requesting slot wins
    assign slot_grant_o = slot_req_i & (~slot_req_i + 1'b1);

    always_comb begin
        cdb_valid_o = 1'b0;
        cdb_tag_o   = '0;
        cdb_data_o  = '0;
        for (int i = `OOO_NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_req_i[i]) begin
                cdb_valid_o = 1'b1;
                cdb_tag_o   = slot_tag_i[i];
                cdb_data_o  = slot_result_i[i];
            end
        end
    end

    // head entry is offered as long as it is finished
    assign commit_valid_o = (count != '0) && done[head];
    assign commit_rd_o    = entry_rd[head];
    assign commit_tag_o   = head;
    assign commit_data_o  = entry_val[head];
    assign commit_fire    = commit_valid_o && commit_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_valid_i) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid_o) begin
                done[cdb_tag_o] <= 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_valid_i) - CNT_W'(commit_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            entry_rd[tail] <= alloc_rd_i;
        end
        if (cdb_valid_o) begin
            entry_val[cdb_tag_o] <= cdb_data_o;
        end
    end

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module ooo_core (
    input  logic               clk,
    input  logic               rst,

    input  logic               instr_valid_i,
    input  ooo_pkg::alu_op_t   instr_op_i,
    input  ooo_pkg::reg_addr_t instr_rd_i,
    input  ooo_pkg::reg_addr_t instr_rs1_i,
    input  ooo_pkg::reg_addr_t instr_rs2_i,
    input  ooo_pkg::word_t     instr_imm_i,
    input  logic               instr_use_imm_i,
    output logic               instr_ready_o,

    output logic               commit_valid_o,
    output ooo_pkg::reg_addr_t commit_rd_o,
    output ooo_pkg::word_t     commit_data_o,
    input  logic               commit_ready_i
);

    logic [`OOO_NUM_SLOTS-1:0] slot_free, slot_load, slot_req, slot_grant;
    ooo_pkg::rob_tag_t         slot_tag    [`OOO_NUM_SLOTS];
    ooo_pkg::word_t            slot_result [`OOO_NUM_SLOTS];

    ooo_pkg::alu_op_t          disp_op;
    ooo_pkg::rob_tag_t         disp_tag, disp_src1_tag, disp_src2_tag;
    logic                      disp_src1_ready, disp_src2_ready;
    ooo_pkg::word_t            disp_src1_data, disp_src2_data;

    logic                      alloc_valid;
    ooo_pkg::reg_addr_t        alloc_rd;
    ooo_pkg::rob_tag_t         rob_tag;
    logic                      rob_full;
    logic [`OOO_ROB_DEPTH-1:0] rob_done;
    ooo_pkg::word_t            rob_data [`OOO_ROB_DEPTH];

    logic                      cdb_valid;
    ooo_pkg::rob_tag_t         cdb_tag;
    ooo_pkg::word_t            cdb_data;
    ooo_pkg::rob_tag_t         commit_tag;

    rename_dispatch u_rename (
        .clk(clk), .rst(rst),
        .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i), .instr_rd_i(instr_rd_i),
        .instr_rs1_i(instr_rs1_i), .instr_rs2_i(instr_rs2_i), .instr_imm_i(instr_imm_i),
        .instr_use_imm_i(instr_use_imm_i), .instr_ready_o(instr_ready_o),
        .slot_free_i(slot_free), .slot_load_o(slot_load),
        .rob_tag_i(rob_tag), .rob_full_i(rob_full), .rob_done_i(rob_done),
        .rob_data_i(rob_data), .alloc_valid_o(alloc_valid), .alloc_rd_o(alloc_rd),
        .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
        .commit_fire_i(commit_valid_o && commit_ready_i), .commit_rd_i(commit_rd_o),
        .commit_tag_i(commit_tag), .commit_data_i(commit_data_o),
        .disp_op_o(disp_op), .disp_tag_o(disp_tag),
        .disp_src1_ready_o(disp_src1_ready), .disp_src1_tag_o(disp_src1_tag),
        .disp_src1_data_o(disp_src1_data),
        .disp_src2_ready_o(disp_src2_ready), .disp_src2_tag_o(disp_src2_tag),
        .disp_src2_data_o(disp_src2_data)
    );

    // identical reservation station entries
    for (genvar i = 0; i < `OOO_NUM_SLOTS; i++) begin : g_slot
        issue_slot u_slot (
            .clk(clk), .rst(rst),
            .load_i(slot_load[i]), .disp_op_i(disp_op), .disp_tag_i(disp_tag),
            .disp_src1_ready_i(disp_src1_ready), .disp_src1_tag_i(disp_src1_tag),
            .disp_src1_data_i(disp_src1_data),
            .disp_src2_ready_i(disp_src2_ready), .disp_src2_tag_i(disp_src2_tag),
            .disp_src2_data_i(disp_src2_data),
            .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
            .grant_i(slot_grant[i]), .free_o(slot_free[i]), .req_o(slot_req[i]),
            .tag_o(slot_tag[i]), .result_o(slot_result[i])
        );
    end

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .alloc_valid_i(alloc_valid), .alloc_rd_i(alloc_rd), .alloc_tag_o(rob_tag),
        .full_o(rob_full), .done_o(rob_done), .data_o(rob_data),
        .slot_req_i(slot_req), .slot_tag_i(slot_tag), .slot_result_i(slot_result),
        .slot_grant_o(slot_grant),
        .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_data_o(cdb_data),
        .commit_ready_i(commit_ready_i), .commit_valid_o(commit_valid_o),
        .commit_rd_o(commit_rd_o), .commit_tag_o(commit_tag), .commit_data_o(commit_data_o)
    );

endmodule

// ==== verif/ooo_core_tb.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module ooo_core_tb;

    localparam int NUM_INSTR  = 300;
    localparam int MAX_CYCLES = 20000;

    logic               clk;
    logic               rst;
    logic               instr_valid_i;
    ooo_pkg::alu_op_t   instr_op_i;
    ooo_pkg::reg_addr_t instr_rd_i;
    ooo_pkg::reg_addr_t instr_rs1_i;
    ooo_pkg::reg_addr_t instr_rs2_i;
    ooo_pkg::word_t     instr_imm_i;
    logic               instr_use_imm_i;
    logic               instr_ready_o;
    logic               commit_valid_o;
    ooo_pkg::reg_addr_t commit_rd_o;
    ooo_pkg::word_t     commit_data_o;
    logic               commit_ready_i;

    integer             seed;
    int                 mismatch_count;
    int                 fail_count;
    int                 accepts;
    int                 commits;
    int                 cycles;
    int                 stall_left;
    logic               accept_now;
    logic               full_seen;
    logic               hold_valid;
    ooo_pkg::reg_addr_t hold_rd;
    ooo_pkg::word_t     hold_data;
    ooo_pkg::reg_addr_t recent_rd [3];
    ooo_pkg::word_t     model_rf [`OOO_NUM_REGS];
    logic [15:0]        covered;

    // expected commits in acceptance order
    ooo_pkg::reg_addr_t exp_rd_q [$];
    ooo_pkg::word_t     exp_data_q [$];
    int                 exp_kind_q [$];

    ooo_core DUT (
        .clk(clk), .rst(rst),
        .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i), .instr_rd_i(instr_rd_i),
        .instr_rs1_i(instr_rs1_i), .instr_rs2_i(instr_rs2_i), .instr_imm_i(instr_imm_i),
        .instr_use_imm_i(instr_use_imm_i), .instr_ready_o(instr_ready_o),
        .commit_valid_o(commit_valid_o), .commit_rd_o(commit_rd_o),
        .commit_data_o(commit_data_o), .commit_ready_i(commit_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reference result of each op
    function automatic ooo_pkg::word_t expected_result(ooo_pkg::alu_op_t op,
                                                       ooo_pkg::word_t a, ooo_pkg::word_t b);
        ooo_pkg::word_t r;
        r = '0;
        case (op)
            `OOO_OP_ADD: r = a + b;
            `OOO_OP_SUB: r = a - b;
            `OOO_OP_AND: r = a & b;
            `OOO_OP_OR:  r = a | b;
            `OOO_OP_XOR: r = a ^ b;
            `OOO_OP_SLL: r = a << b[4:0];
            `OOO_OP_SRL: r = a >> b[4:0];
            `OOO_OP_SLT: begin
                // differing signs decide on their own
                if (a[`OOO_XLEN-1] != b[`OOO_XLEN-1]) begin
                    r[0] = a[`OOO_XLEN-1];
                end else begin
                    r[0] = (a < b);
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_reg_addr(input string name, input ooo_pkg::reg_addr_t got,
                                  input ooo_pkg::reg_addr_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input ooo_pkg::word_t got,
                              input ooo_pkg::word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        fail_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic draw(output logic [31:0] v);
        v = $random(seed);
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        draw(r);
        draw(r2);
        draw(r3);
        // a pending instruction holds until accepted
        if (!(instr_valid_i && !accept_now)) begin
            instr_valid_i = (accepts < NUM_INSTR) && (r[1:0] != 2'b00);
            instr_op_i    = r[4:2];
            // x24 and up are never written
            instr_rd_i    = ooo_pkg::reg_addr_t'(r2 % 32'd24);
            if (r[5]) begin
                instr_rs1_i = recent_rd[int'(r[7:6]) % 3];
            end else begin
                instr_rs1_i = r[12:8];
            end
            if (r[13]) begin
                instr_rs2_i = recent_rd[int'(r[15:14]) % 3];
            end else begin
                instr_rs2_i = r[20:16];
            end
            instr_use_imm_i = r[21];
            instr_imm_i     = r[22] ? {{24{r3[7]}}, r3[7:0]} : r3;
        end
        if (stall_left > 0) begin
            commit_ready_i = 1'b0;
            stall_left--;
        end else if (r[28:23] == 6'd0) begin
            commit_ready_i = 1'b0;
            stall_left     = 16 + int'(r[31:29]) * 4;
        end else begin
            commit_ready_i = (r2[31:30] != 2'b00);
        end
    endtask

    task automatic sample_outputs();
        ooo_pkg::word_t a;
        ooo_pkg::word_t b;
        if (hold_valid) begin
            if (commit_valid_o !== 1'b1) begin
                report_failure("commit_valid_o dropped while commit_ready_i was low");
            end else begin
                check_reg_addr("commit_rd_o (stalled)", commit_rd_o, hold_rd);
                check_word("commit_data_o (stalled)", commit_data_o, hold_data);
            end
        end
        hold_valid = (commit_valid_o === 1'b1) && !commit_ready_i;
        hold_rd    = commit_rd_o;
        hold_data  = commit_data_o;
        if (exp_rd_q.size() >= `OOO_ROB_DEPTH) begin
            full_seen = 1'b1;
            if (instr_ready_o !== 1'b0) begin
                report_failure("instr_ready_o high with a full reorder buffer");
            end
        end
        if (commit_valid_o === 1'b1 && commit_ready_i) begin
            if (exp_rd_q.size() == 0) begin
                report_failure("commit with an empty model queue");
            end else begin
                check_reg_addr("commit_rd_o", commit_rd_o, exp_rd_q[0]);
                check_word("commit_data_o", commit_data_o, exp_data_q[0]);
                covered[exp_kind_q[0]] = 1'b1;
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_kind_q.pop_front());
                commits++;
            end
        end
        accept_now = instr_valid_i && (instr_ready_o === 1'b1);
        if (accept_now) begin
            a = model_rf[instr_rs1_i];
            b = instr_use_imm_i ? instr_imm_i : model_rf[instr_rs2_i];
            exp_rd_q.push_back(instr_rd_i);
            exp_data_q.push_back(expected_result(instr_op_i, a, b));
            exp_kind_q.push_back(int'(instr_op_i) * 2 + int'(instr_use_imm_i));
            if (instr_rd_i != '0) begin
                model_rf[instr_rd_i] = expected_result(instr_op_i, a, b);
            end
            recent_rd[2] = recent_rd[1];
            recent_rd[1] = recent_rd[0];
            recent_rd[0] = instr_rd_i;
            accepts++;
        end
    endtask

    initial begin
        seed            = 32'hf56;
        mismatch_count  = 0;
        fail_count      = 0;
        accepts         = 0;
        commits         = 0;
        cycles          = 0;
        stall_left      = 0;
        accept_now      = 1'b0;
        full_seen       = 1'b0;
        hold_valid      = 1'b0;
        hold_rd         = '0;
        hold_data       = '0;
        covered         = '0;
        rst             = 1'b1;
        instr_valid_i   = 1'b0;
        instr_op_i      = '0;
        instr_rd_i      = '0;
        instr_rs1_i     = '0;
        instr_rs2_i     = '0;
        instr_imm_i     = '0;
        instr_use_imm_i = 1'b0;
        commit_ready_i  = 1'b0;
        recent_rd[0]    = 5'd1;
        recent_rd[1]    = 5'd2;
        recent_rd[2]    = 5'd3;
        for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            model_rf[i] = ooo_pkg::word_t'(i);
        end

        repeat (15) begin
            @(posedge clk);
            @(negedge clk);
            if (instr_ready_o !== 1'b0 || commit_valid_o !== 1'b0) begin
                report_failure("instr_ready_o or commit_valid_o not low during reset");
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (instr_ready_o !== 1'b1) begin
            report_failure("instr_ready_o not high in the first cycle after reset");
        end
        if (commit_valid_o !== 1'b0) begin
            report_failure("commit_valid_o high right after reset");
        end

        while (commits < NUM_INSTR && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
            cycles++;
        end

        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles with %0d of %0d commits",
                                     cycles, commits, NUM_INSTR));
        end else begin
            // nothing else may retire
            @(posedge clk);
            #1;
            instr_valid_i  = 1'b0;
            commit_ready_i = 1'b1;
            repeat (16) begin
                @(negedge clk);
                if (commit_valid_o !== 1'b0) begin
                    report_failure("commit_valid_o high after the last expected commit");
                end
                @(posedge clk);
            end
        end
        if (exp_rd_q.size() != 0) begin
            report_failure($sformatf("%0d accepted instructions never committed",
                                     exp_rd_q.size()));
        end
        if (!full_seen) begin
            report_failure("the reorder buffer never filled during a commit stall");
        end
        for (int k = 0; k < 16; k++) begin
            if (!covered[k]) begin
                report_failure($sformatf("op %0d never committed in %s form", k / 2,
                                         (k % 2) ? "immediate" : "register"));
            end
        end

        $display("errors: %0d mismatches, %0d other failures, %0d commits checked",
                 mismatch_count, fail_count, commits);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== ooo_core.f ====
+incdir+logic
logic/ooo_pkg.sv
logic/rename_dispatch.sv
logic/issue_slot.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
verif/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the ooo_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ooo_core_tb -f ooo_core.f -o ooo_core_sim
./obj_dir/ooo_core_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: FAIL"
    exit 1
fi
echo "run_sim: PASS"
